// File: files.f
rtl/video_pkg.sv
rtl/text_pkg.sv
rtl/text_ram.sv
rtl/credits_regs.sv
rtl/credits_scan.sv
rtl/credits_mixer.sv
rtl/credits_top.sv
verif/credits_tb.sv

// File: rtl/credits_mixer.sv
`default_nettype none

module credits_mixer
    import video_pkg::*;
(
    input  wire           clk,
    input  wire           pxl_cen,
    input  wire           hb,
    input  wire           vb,
    input  wire rgb_t     rgb_in,
    input  wire           enable,
    input  wire           glyph_on,
    input  wire pal_idx_t glyph_pal,
    output logic          hb_out,
    output logic          vb_out,
    output rgb_t          rgb_out
);

    localparam int STAGES = PIPE_DEPTH - 1; // output register is the last stage

    rgb_t              rgb_dly [STAGES];
    logic [STAGES-1:0] hb_dly, vb_dly;
    rgb_t              held;
    rgb_t              dim;
    rgb_t              mixed;

    assign held = rgb_dly[STAGES-1];

    // half brightness per component
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            dim[i*COLW +: COLW] = held[i*COLW +: COLW] >> 1;
        end
    end

    always_comb begin
        mixed = dim;
        if (glyph_on) begin
            case (glyph_pal)
                2'd0:    mixed = PAL0;
                2'd1:    mixed = PAL1;
                2'd2:    mixed = PAL2;
                default: mixed = PAL3;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_dly[0] <= rgb_in;
            hb_dly[0]  <= hb;
            vb_dly[0]  <= vb;
            for (int i = 1; i < STAGES; i++) begin
                rgb_dly[i] <= rgb_dly[i-1];
                hb_dly[i]  <= hb_dly[i-1];
                vb_dly[i]  <= vb_dly[i-1];
            end
            hb_out  <= hb_dly[STAGES-1];
            vb_out  <= vb_dly[STAGES-1];
            rgb_out <= enable ? mixed : held;
        end
    end

endmodule

`default_nettype wire

// File: rtl/credits_regs.sv
`default_nettype none

module credits_regs
    import text_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    // write address and data
    input  wire [AXI_AW-1:0]    awaddr,
    input  wire                 awvalid,
    output logic                awready,
    input  wire [AXI_DW-1:0]    wdata,
    input  wire                 wvalid,
    output logic                wready,
    // write response
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  wire                 bready,
    // read
    input  wire [AXI_AW-1:0]    araddr,
    input  wire                 arvalid,
    output logic                arready,
    output logic [AXI_DW-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  wire                 rready,
    // memory write ports
    output logic                msg_we,
    output msg_addr_t           msg_waddr,
    output msg_entry_t          msg_wdata,
    output logic                font_we,
    output font_addr_t          font_waddr,
    output font_row_t           font_wdata,
    // control
    output logic                enable,
    output speed_t              speed
);

    logic wr_hs, rd_hs;
    logic wr_in_map, rd_in_map;
    logic [AXI_DW-1:0] ctrl_word;

    assign wr_hs     = awvalid && awready && wvalid && wready;
    assign rd_hs     = arvalid && arready;
    assign wr_in_map = awaddr < MAP_END;
    assign rd_in_map = araddr < MAP_END;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_EN_BIT] = enable;
        ctrl_word[CTRL_SPD_LSB +: $bits(speed_t)] = speed;
    end

    // AW and W are taken together, one write in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            msg_we  <= 1'b0;
            font_we <= 1'b0;
            enable  <= 1'b0;
            speed   <= '0;
        end else begin
            msg_we  <= 1'b0;
            font_we <= 1'b0;
            if (wr_hs) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= wr_in_map ? RESP_OKAY : RESP_SLVERR;
                if (awaddr == CTRL_ADDR) begin
                    enable <= wdata[CTRL_EN_BIT];
                    speed  <= wdata[CTRL_SPD_LSB +: $bits(speed_t)];
                end
                font_we <= awaddr[15:12] == FONT_BASE[15:12];
                msg_we  <= awaddr[15:13] == MSG_BASE[15:13]; // covers 0x2000..0x3fff
            end else if (!bvalid && !awready && awvalid && wvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            msg_waddr  <= awaddr[2 +: $bits(msg_addr_t)];  // word stride
            msg_wdata  <= msg_entry_t'(wdata[$bits(msg_entry_t)-1:0]);
            font_waddr <= awaddr[2 +: $bits(font_addr_t)];
            font_wdata <= wdata[$bits(font_row_t)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
        end else if (rd_hs) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            rresp   <= rd_in_map ? RESP_OKAY : RESP_SLVERR;
        end else if (!rvalid && !arready && arvalid) begin
            arready <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    // only the control register reads back
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= (araddr == CTRL_ADDR) ? ctrl_word : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/credits_scan.sv
`default_nettype none

module credits_scan
    import video_pkg::*;
    import text_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         pxl_cen,
    input  wire         hb,
    input  wire         vb,
    input  wire speed_t speed,
    output msg_addr_t   msg_raddr,
    input  wire msg_entry_t msg_q,
    output font_addr_t  font_raddr,
    input  wire font_row_t  font_q,
    output logic        glyph_on,
    output pal_idx_t    glyph_pal
);

    logic [7:0] x;          // index of the pixel at the input
    logic       x_over;     // past pixel 255
    logic [7:0] y;
    logic       last_hb, last_vb;
    speed_t     frame_cnt;
    scroll_t    scroll;
    scroll_t    eff;        // line within the message
    logic [8:0] col_ahead;
    font_row_t  shift;
    pal_idx_t   pal;
    logic       vis;

    assign eff        = scroll + scroll_t'(y);
    assign col_ahead  = {1'b0, x} + 9'd3; // msg then font read, 3 pixels of lead
    assign font_raddr = {msg_q.code, eff[2:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            x         <= '0;
            x_over    <= 1'b0;
            y         <= '0;
            last_hb   <= 1'b0;
            last_vb   <= 1'b0;
            frame_cnt <= '0;
            scroll    <= '0;
            vis       <= 1'b0;
            glyph_on  <= 1'b0;
        end else if (pxl_cen) begin
            last_hb <= hb;
            last_vb <= vb;
            if (hb) begin
                x      <= '0;
                x_over <= 1'b0;
            end else if (x == 8'hff) begin
                x_over <= 1'b1;
            end else begin
                x <= x + 8'd1;
            end
            if (vb) begin
                y <= '0;
            end else if (hb && !last_hb) begin
                y <= y + 8'd1;
            end
            // scroll one line every speed+1 frames
            if (vb && !last_vb) begin
                if (frame_cnt >= speed) begin
                    frame_cnt <= '0;
                    scroll    <= scroll + scroll_t'(1);
                end else begin
                    frame_cnt <= frame_cnt + speed_t'(1);
                end
            end
            vis      <= !hb && !vb && !x_over;
            glyph_on <= shift[7] && vis; // pixel now in mixer stage 2
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            msg_raddr <= {eff[8:3], col_ahead[7:3]};
            glyph_pal <= pal;
            if (x[2:0] == 3'd0) begin
                shift <= font_q;
                pal   <= msg_q.pal;
            end else begin
                shift <= shift << 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/credits_top.sv
`default_nettype none

module credits_top
    import video_pkg::*;
    import text_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    // video in
    input  wire                 pxl_cen,
    input  wire                 hb,
    input  wire                 vb,
    input  wire rgb_t           rgb_in,
    // video out
    output logic                hb_out,
    output logic                vb_out,
    output rgb_t                rgb_out,
    // AXI4-Lite slave
    input  wire [AXI_AW-1:0]    awaddr,
    input  wire                 awvalid,
    output logic                awready,
    input  wire [AXI_DW-1:0]    wdata,
    input  wire                 wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  wire                 bready,
    input  wire [AXI_AW-1:0]    araddr,
    input  wire                 arvalid,
    output logic                arready,
    output logic [AXI_DW-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  wire                 rready
);

    logic       msg_we, font_we;
    msg_addr_t  msg_waddr, msg_raddr;
    msg_entry_t msg_wdata, msg_q;
    font_addr_t font_waddr, font_raddr;
    font_row_t  font_wdata, font_q;
    logic       enable;
    speed_t     speed;
    logic       glyph_on;
    pal_idx_t   glyph_pal;

    credits_regs u_regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .msg_we, .msg_waddr, .msg_wdata,
        .font_we, .font_waddr, .font_wdata,
        .enable, .speed
    );

    text_ram #(.word_t(msg_entry_t), .DEPTH(MSG_DEPTH)) u_msg (
        .clk, .we(msg_we), .waddr(msg_waddr), .wdata(msg_wdata),
        .raddr(msg_raddr), .q(msg_q)
    );

    text_ram #(.word_t(font_row_t), .DEPTH(FONT_DEPTH)) u_font (
        .clk, .we(font_we), .waddr(font_waddr), .wdata(font_wdata),
        .raddr(font_raddr), .q(font_q)
    );

    credits_scan u_scan (
        .clk, .rst, .pxl_cen, .hb, .vb, .speed,
        .msg_raddr, .msg_q, .font_raddr, .font_q,
        .glyph_on, .glyph_pal
    );

    credits_mixer u_mixer (
        .clk, .pxl_cen, .hb, .vb, .rgb_in,
        .enable, .glyph_on, .glyph_pal,
        .hb_out, .vb_out, .rgb_out
    );

endmodule

`default_nettype wire

// File: rtl/text_pkg.sv
`default_nettype none

package text_pkg;

    // message layout, 64 rows of 32 characters
    localparam int MSG_COLS  = 32;
    localparam int MSG_ROWS  = 64;
    localparam int MSG_DEPTH = MSG_COLS * MSG_ROWS;

    // 128 characters, 8 rows each
    localparam int FONT_CHARS = 128;
    localparam int FONT_DEPTH = FONT_CHARS * 8;

    typedef logic [$clog2(MSG_DEPTH)-1:0]  msg_addr_t;  // row * 32 + column
    typedef logic [$clog2(FONT_DEPTH)-1:0] font_addr_t; // code * 8 + glyph row
    typedef logic [7:0] font_row_t;                     // bit 7 is the leftmost pixel
    typedef logic [8:0] scroll_t;                       // wraps over 512 lines
    typedef logic [3:0] speed_t;

    typedef struct packed {
        logic [1:0] pal;
        logic [6:0] code;
    } msg_entry_t;

    // AXI4-Lite register map
    localparam int AXI_AW = 16;
    localparam int AXI_DW = 32;

    localparam logic [AXI_AW-1:0] CTRL_ADDR = 16'h0000;
    localparam logic [AXI_AW-1:0] FONT_BASE = 16'h1000; // 0x1000..0x1ffc
    localparam logic [AXI_AW-1:0] MSG_BASE  = 16'h2000; // 0x2000..0x3ffc
    localparam logic [AXI_AW-1:0] MAP_END   = 16'h4000; // SLVERR from here up

    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_SPD_LSB = 4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: rtl/text_ram.sv
`default_nettype none

// simple dual port, one write port and one registered read port
module text_ram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 1024
) (
    input  wire                       clk,
    input  wire                       we,
    input  wire [$clog2(DEPTH)-1:0]   waddr,
    input  wire word_t                wdata,
    input  wire [$clog2(DEPTH)-1:0]   raddr,
    output word_t                     q
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        q <= mem[raddr]; // one clock read latency
    end

endmodule

`default_nettype wire

// File: rtl/video_pkg.sv
`default_nettype none

package video_pkg;

    localparam int COLW = 4; // bits per colour component

    // red in the top bits, then green, then blue
    typedef logic [3*COLW-1:0] rgb_t;

    typedef logic [1:0] pal_idx_t;

    // glyph colours picked by the message entry
    localparam rgb_t PAL0 = {4'hf, 4'h0, 4'h0}; // red
    localparam rgb_t PAL1 = {4'h0, 4'hf, 4'h0}; // green
    localparam rgb_t PAL2 = {4'h3, 4'h3, 4'hf}; // blue, lifted a little
    localparam rgb_t PAL3 = {4'hf, 4'hf, 4'hf}; // white

    // pxl_cen stages from rgb_in to rgb_out
    localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module credits_tb -o credits_sim

out=$(./obj_dir/credits_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verif/credits_tb.sv
`default_nettype none

module credits_tb
    import video_pkg::*;
    import text_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // video source geometry
    localparam int LINE_ACT  = 40;
    localparam int LINE_LEN  = 48;
    localparam int FRAME_ACT = 6;
    localparam int FRAME_LEN = 8;
    localparam int FRAME_CYCLES = 2 * LINE_LEN * FRAME_LEN; // pxl_cen every second clock
    localparam int N_FRAMES     = 10;                       // 1 + 2 + 1 + 6 over all tests
    localparam int CYCLE_LIMIT  = 4 * N_FRAMES * FRAME_CYCLES;
    localparam int LAG = PIPE_DEPTH - 1; // pixels still in flight after a capture edge

    typedef struct packed {
        logic     hb;
        logic     vb;
        logic     on;
        pal_idx_t pal;
        rgb_t     rgb;
    } pix_t;

    logic clk, rst, pxl_cen, hb, vb;
    rgb_t rgb_in, rgb_out;
    logic hb_out, vb_out;
    logic [AXI_AW-1:0] awaddr, araddr;
    logic [AXI_DW-1:0] wdata, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;

    // reference copy of memories and scroll state
    font_row_t  font_m [FONT_DEPTH];
    msg_entry_t msg_m [MSG_DEPTH];
    scroll_t    scroll_m;
    speed_t     speed_m;
    int         fcnt_m; // vb rises since the last scroll step
    logic       en_m, last_vb_m;
    pix_t       hist [$];
    integer     seed = 32'hf293;
    int         cycles;
    string      cur_test;

    credits_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "check failed in %s", cur_test);
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s rgb_out %h expected %h", $time, cur_test, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_blank(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s hb/vb out %b expected %b", $time, cur_test, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s axi resp %b expected %b", $time, cur_test, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_data(input logic [AXI_DW-1:0] got, input logic [AXI_DW-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s rdata %h expected %h", $time, cur_test, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        step();
        rst = 1'b1;
        pxl_cen = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        scroll_m = '0;
        fcnt_m = 0;
        speed_m = '0;
        en_m = 1'b0;
        last_vb_m = 1'b0;
        hist.delete();
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             output logic [1:0] resp);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b1;
        do step(); while (!awready);
        step(); // AW and W taken here
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) step();
        resp = bresp;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                            output logic [1:0] resp);
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b1;
        do step(); while (!arready);
        step();
        arvalid = 1'b0;
        while (!rvalid) step();
        data = rdata;
        resp = rresp;
        step();
        rready = 1'b0;
    endtask

    task automatic set_ctrl(input logic en, input speed_t spd);
        logic [1:0] resp;
        axi_write(CTRL_ADDR, 32'({spd, 3'b000, en}), resp); // speed in 7:4 and enable in 0
        check_resp(resp, RESP_OKAY);
        en_m = en;
        speed_m = spd;
    endtask

    function automatic rgb_t palette_colour(input pal_idx_t idx);
        case (idx)
            2'd0:    return PAL0;
            2'd1:    return PAL1;
            2'd2:    return PAL2;
            default: return PAL3;
        endcase
    endfunction

    function automatic rgb_t expected_rgb(input pix_t p);
        rgb_t half;
        half = {1'b0, p.rgb[11:9], 1'b0, p.rgb[7:5], 1'b0, p.rgb[3:1]};
        if (!en_m) return p.rgb;
        if (p.on) return palette_colour(p.pal);
        return half;
    endfunction

    // one pixel goes in while the pixel LAG places back is checked at the output
    task automatic drive_pixel(input logic h, input logic v, input int x, input int y);
        pix_t       p;
        pix_t       q;
        scroll_t    eff;
        msg_entry_t ent;
        font_row_t  row;
        step();
        p = '0;
        p.hb = h;
        p.vb = v;
        p.rgb = rgb_t'($random(seed));
        pxl_cen = 1'b1;
        hb = h;
        vb = v;
        rgb_in = p.rgb;
        // every (speed+1)-th rising vb moves the text up one line
        if (v && !last_vb_m) begin
            fcnt_m++;
            if (fcnt_m == int'(speed_m) + 1) begin
                fcnt_m = 0;
                scroll_m = scroll_m + 9'd1;
            end
        end
        last_vb_m = v;
        if (!h && !v && x < 256) begin
            eff = scroll_m + scroll_t'(y);
            ent = msg_m[msg_addr_t'(int'(eff[8:3]) * MSG_COLS + x / 8)];
            row = font_m[font_addr_t'(int'(ent.code) * 8 + int'(eff[2:0]))];
            p.on = row[3'(7 - x % 8)]; // bit 7 is leftmost
            p.pal = ent.pal;
        end
        hist.push_back(p);
        step(); // capture edge
        pxl_cen = 1'b0;
        if (hist.size() > LAG) begin
            q = hist.pop_front();
            check_blank({hb_out, vb_out}, {q.hb, q.vb});
            check_rgb(rgb_out, expected_rgb(q));
        end
    endtask

    // blank lines come before active lines, and each line ends in hb
    task automatic run_frames(input int n);
        for (int f = 0; f < n; f++) begin
            for (int ln = 0; ln < FRAME_LEN; ln++) begin
                for (int px = 0; px < LINE_LEN; px++) begin
                    drive_pixel(px >= LINE_ACT, ln < FRAME_LEN - FRAME_ACT, px,
                                ln - (FRAME_LEN - FRAME_ACT));
                end
            end
        end
    endtask

    task automatic load_text();
        logic [1:0] resp;
        msg_entry_t ent;
        font_row_t  row;
        for (int i = 0; i < 16 * 8; i++) begin // glyphs for codes 0..15
            row = font_row_t'($random(seed));
            axi_write(16'(FONT_BASE + 4 * i), 32'(row), resp);
            check_resp(resp, RESP_OKAY);
            font_m[font_addr_t'(i)] = row;
        end
        for (int i = 0; i < 2 * MSG_COLS; i++) begin
            ent.pal = pal_idx_t'($random(seed));
            ent.code = 7'($random(seed) & 15);
            axi_write(16'(MSG_BASE + 4 * i), 32'(ent), resp);
            check_resp(resp, RESP_OKAY);
            msg_m[msg_addr_t'(i)] = ent;
        end
    endtask

    task automatic test_registers();
        logic [AXI_DW-1:0] data;
        logic [1:0]        resp;
        cur_test = "registers";
        axi_read(CTRL_ADDR, data, resp);
        check_resp(resp, RESP_OKAY);
        check_data(data, '0);
        set_ctrl(1'b1, 4'd1);
        axi_read(CTRL_ADDR, data, resp);
        check_resp(resp, RESP_OKAY);
        check_data(data, 32'h11);
        axi_write(16'h4000, 32'h0, resp); // outside the map
        check_resp(resp, RESP_SLVERR);
        axi_read(CTRL_ADDR, data, resp);
        check_resp(resp, RESP_OKAY);
        check_data(data, 32'h11);
        axi_read(16'h4000, data, resp);
        check_resp(resp, RESP_SLVERR);
        check_data(data, '0);
        axi_read(MSG_BASE, data, resp); // memories do not read back
        check_resp(resp, RESP_OKAY);
        check_data(data, '0);
        set_ctrl(1'b0, 4'd0);
    endtask

    task automatic test_passthrough();
        cur_test = "passthrough";
        run_frames(1);
    endtask

    task automatic test_glyphs();
        cur_test = "glyphs";
        apply_reset();
        set_ctrl(1'b1, 4'd15); // scroll stays 0 for these frames
        run_frames(2);
    endtask

    task automatic test_palette();
        logic [1:0] resp;
        msg_entry_t ent;
        cur_test = "palette";
        for (int r = 0; r < 8; r++) begin
            axi_write(16'(FONT_BASE + 4 * (127 * 8 + r)), 32'hff, resp);
            check_resp(resp, RESP_OKAY);
            font_m[font_addr_t'(127 * 8 + r)] = 8'hff;
        end
        for (int c = 0; c < 4; c++) begin
            ent.pal = pal_idx_t'(c);
            ent.code = 7'd127;
            axi_write(16'(MSG_BASE + 4 * c), 32'(ent), resp);
            check_resp(resp, RESP_OKAY);
            msg_m[msg_addr_t'(c)] = ent;
        end
        run_frames(1);
    endtask

    task automatic test_scroll();
        cur_test = "scroll";
        apply_reset();
        set_ctrl(1'b1, 4'd1); // one line every two frames
        run_frames(6);
    endtask

    initial begin
        rst = 1'b1;
        pxl_cen = 1'b0;
        hb = 1'b0;
        vb = 1'b0;
        rgb_in = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        cur_test = "reset";
        apply_reset();
        test_registers();
        load_text();
        test_passthrough();
        test_glyphs();
        test_palette();
        test_scroll();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
